// File: src/cache_pkg.sv
package cache_pkg;

	typedef logic [31:0]  word;
	typedef logic [127:0] line;
	typedef logic [15:0]  line_be;

	typedef logic [2:0]  addr_io_region;
	typedef logic [18:0] addr_tag;
	typedef logic [5:0]  addr_index;
	typedef logic [3:0]  addr_offset;

	localparam int NUM_LINES  = 1 << $bits(addr_index);
	localparam int LINE_BYTES = 1 << $bits(addr_offset);

	// Field order follows the bit order of the address, region on top.
	typedef struct packed {
		addr_io_region region;
		addr_tag       tag;
		addr_index     index;
		addr_offset    offset;
	} addr_fields_t;

	typedef union packed {
		word          flat;
		addr_fields_t f;
	} addr_t;

	localparam addr_io_region CACHED_REGION = 3'd0; // Only this region goes through the cache.

endpackage

// File: src/bus_pkg.sv
package bus_pkg;

	import cache_pkg::*;

	// Core side request, held stable by the core while waitrequest is high.
	typedef struct packed {
		addr_t  address;
		logic   read;
		logic   write;
		line    writedata;
		line_be byteenable;
	} core_req_t;

	// Memory side request, always line aligned.
	typedef struct packed {
		word    address;
		logic   read;
		logic   write;
		line    writedata;
		line_be byteenable;
	} mem_req_t;

endpackage

// File: src/cache_routing.sv
module cache_routing
	import cache_pkg::*;
	import bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  core_req_t  core_req,
	output logic       core_waitrequest,
	output line        core_readdata,

	output addr_tag    core_tag,
	output addr_index  core_index,
	output addr_offset core_offset,
	output logic       cache_core_read,
	output logic       cache_core_write,
	input  logic       cache_core_waitrequest,
	input  line        data_rd,

	input  mem_req_t   cache_mem_req,
	output logic       cache_mem_waitrequest,

	input  logic       mem_waitrequest,
	input  line        mem_readdata,
	output mem_req_t   mem_req
);

	typedef enum logic [1:0] {IDLE, CACHE, BYPASS} state_t;

	state_t state;
	addr_t  line_addr;
	logic   cached, cache_mem, bypass, transition;
	logic   mem_read_q, mem_write_q;
	word    mem_address_q;
	line    mem_writedata_q;
	line_be mem_byteenable_q;

	assign cached = core_req.address.f.region == CACHED_REGION;
	assign cache_mem = cache_mem_req.read || cache_mem_req.write;
	assign bypass = !cached && (core_req.read || core_req.write);
	assign transition = (state == IDLE) && (cache_mem || bypass);

	assign core_tag = core_req.address.f.tag;
	assign core_index = core_req.address.f.index;
	assign core_offset = core_req.address.f.offset;

	assign cache_core_read = core_req.read && cached;
	assign cache_core_write = core_req.write && cached;
	assign core_readdata = cached ? data_rd : mem_readdata;

	always_comb begin
		line_addr = core_req.address;
		line_addr.f.offset = '0; // Memory only moves whole lines.
	end

	// Whoever owns the port sees the memory waitrequest directly.
	always_comb begin
		core_waitrequest = cached ? cache_core_waitrequest : 1'b1;
		cache_mem_waitrequest = 1'b1;
		case (state)
			CACHE:   cache_mem_waitrequest = mem_waitrequest;
			BYPASS:  core_waitrequest = mem_waitrequest;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			mem_read_q <= 1'b0;
			mem_write_q <= 1'b0;
		end else begin
			case (state)
				IDLE: if (transition) begin
					state <= cache_mem ? CACHE : BYPASS; // Controller wins a tie.
					mem_read_q <= cache_mem ? cache_mem_req.read : core_req.read;
					mem_write_q <= cache_mem ? cache_mem_req.write : core_req.write;
				end
				default: if (!mem_waitrequest) begin
					state <= IDLE;
					mem_read_q <= 1'b0;
					mem_write_q <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (transition) begin
			mem_address_q <= cache_mem ? cache_mem_req.address : line_addr.flat;
			mem_writedata_q <= cache_mem ? cache_mem_req.writedata : core_req.writedata;
			mem_byteenable_q <= cache_mem ? cache_mem_req.byteenable : core_req.byteenable;
		end
	end

	assign mem_req = '{
		address:    mem_address_q,
		read:       mem_read_q,
		write:      mem_write_q,
		writedata:  mem_writedata_q,
		byteenable: mem_byteenable_q
	};

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl
	import cache_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      cache_core_read,
	input  logic      cache_core_write,
	input  addr_tag   core_tag,
	input  addr_index core_index,
	input  line       core_writedata,
	input  line_be    core_byteenable,
	output logic      cache_core_waitrequest,
	output line       data_rd,

	input  addr_tag   hit_tag,
	input  logic      hit_valid,
	input  logic      hit_dirty,
	input  line       hit_data,

	output logic      st_we,
	output addr_index st_index,
	output addr_tag   st_tag,
	output logic      st_dirty,
	output line       st_data,

	output mem_req_t  cache_mem_req,
	input  logic      cache_mem_waitrequest,
	input  line       mem_readdata
);

	typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, UPDATE} state_t;

	state_t state;
	logic   hit, core_req, victim;
	line    merged;
	word    victim_addr, refill_addr;
	logic   mem_read_q, mem_write_q;
	word    mem_address_q;
	line    mem_writedata_q;

	assign core_req = cache_core_read || cache_core_write;
	assign hit = hit_valid && (hit_tag == core_tag);
	assign victim = hit_valid && hit_dirty;

	assign victim_addr = {CACHED_REGION, hit_tag, core_index, addr_offset'(0)};
	assign refill_addr = {CACHED_REGION, core_tag, core_index, addr_offset'(0)};

	always_comb begin
		for (int b = 0; b < LINE_BYTES; b++)
			merged[8*b +: 8] = core_byteenable[b] ? core_writedata[8*b +: 8] : hit_data[8*b +: 8];
	end

	assign data_rd = hit_data;
	assign st_index = core_index;
	assign st_tag = core_tag;

	always_comb begin
		cache_core_waitrequest = 1'b1;
		st_we = 1'b0;
		st_dirty = 1'b0;
		st_data = mem_readdata;
		case (state)
			LOOKUP: if (hit) begin
				cache_core_waitrequest = 1'b0;
				if (cache_core_write) begin
					st_we = 1'b1;
					st_dirty = 1'b1;
					st_data = merged;
				end
			end
			REFILL:  st_we = !cache_mem_waitrequest; // Refilled lines start clean.
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			mem_read_q <= 1'b0;
			mem_write_q <= 1'b0;
		end else begin
			case (state)
				IDLE: if (core_req)
					state <= LOOKUP;
				LOOKUP: if (hit || !core_req) begin
					state <= IDLE;
				end else if (victim) begin
					state <= WRITEBACK;
					mem_write_q <= 1'b1;
				end else begin
					state <= REFILL;
					mem_read_q <= 1'b1;
				end
				WRITEBACK: if (!cache_mem_waitrequest) begin
					state <= REFILL;
					mem_write_q <= 1'b0;
					mem_read_q <= 1'b1;
				end
				REFILL: if (!cache_mem_waitrequest) begin
					state <= UPDATE;
					mem_read_q <= 1'b0;
				end
				UPDATE: state <= LOOKUP; // The store needs a cycle to show the new line.
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LOOKUP) begin
			mem_address_q <= victim ? victim_addr : refill_addr;
			mem_writedata_q <= hit_data;
		end else if (state == WRITEBACK && !cache_mem_waitrequest) begin
			mem_address_q <= refill_addr;
		end
	end

	assign cache_mem_req = '{
		address:    mem_address_q,
		read:       mem_read_q,
		write:      mem_write_q,
		writedata:  mem_writedata_q,
		byteenable: '1
	};

endmodule

// File: src/cache_store.sv
module cache_store
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  addr_index rd_index,

	input  logic      st_we,
	input  addr_index st_index,
	input  addr_tag   st_tag,
	input  logic      st_dirty,
	input  line       st_data,

	output addr_tag   hit_tag,
	output logic      hit_valid,
	output logic      hit_dirty,
	output line       hit_data
);

	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;

	addr_tag tag_mem [NUM_LINES];
	line     data_mem [NUM_LINES];

	// All lines start invalid and clean.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
			hit_valid <= 1'b0;
			hit_dirty <= 1'b0;
		end else begin
			if (st_we) begin
				valid[st_index] <= 1'b1;
				dirty[st_index] <= st_dirty;
			end
			hit_valid <= valid[rd_index];
			hit_dirty <= dirty[rd_index];
		end
	end

	// A read at the written index returns the old contents.
	always_ff @(posedge clk) begin
		if (st_we) begin
			tag_mem[st_index] <= st_tag;
			data_mem[st_index] <= st_data;
		end
		hit_tag <= tag_mem[rd_index];
		hit_data <= data_mem[rd_index];
	end

endmodule

// File: src/cache_top.sv
module cache_top
	import cache_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  core_req_t core_req,
	output logic      core_waitrequest,
	output line       core_readdata,

	output mem_req_t  mem_req,
	input  logic      mem_waitrequest,
	input  line       mem_readdata
);

	addr_tag   core_tag, hit_tag, st_tag;
	addr_index core_index, st_index;
	logic      cache_core_read, cache_core_write, cache_core_waitrequest;
	logic      cache_mem_waitrequest;
	logic      hit_valid, hit_dirty, st_we, st_dirty;
	line       data_rd, hit_data, st_data;
	mem_req_t  cache_mem_req;

	cache_routing routing_i (
		.clk, .rst_n,
		.core_req, .core_waitrequest, .core_readdata,
		.core_tag, .core_index, .core_offset(),
		.cache_core_read, .cache_core_write, .cache_core_waitrequest, .data_rd,
		.cache_mem_req, .cache_mem_waitrequest,
		.mem_waitrequest, .mem_readdata, .mem_req
	);

	cache_ctrl ctrl_i (
		.clk, .rst_n,
		.cache_core_read, .cache_core_write, .core_tag, .core_index,
		.core_writedata(core_req.writedata), .core_byteenable(core_req.byteenable),
		.cache_core_waitrequest, .data_rd,
		.hit_tag, .hit_valid, .hit_dirty, .hit_data,
		.st_we, .st_index, .st_tag, .st_dirty, .st_data,
		.cache_mem_req, .cache_mem_waitrequest, .mem_readdata
	);

	cache_store store_i (
		.clk, .rst_n,
		.rd_index(core_index), // Lookups always follow the live core index.
		.st_we, .st_index, .st_tag, .st_dirty, .st_data,
		.hit_tag, .hit_valid, .hit_dirty, .hit_data
	);

endmodule

// File: dv/cache_mem_model.sv
module cache_mem_model
	import cache_pkg::*;
	import bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t mem_req,
	output logic     mem_waitrequest,
	output line      mem_readdata
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h3b89_86b5;

	line         lines [word]; // Lines that were never written keep their fill pattern.
	logic [31:0] lcg_state;
	logic [1:0]  wait_cnt;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Each byte is the low address byte plus the region number.
	function automatic line stored_line(input word addr);
		line l;
		if (lines.exists(addr))
			return lines[addr];
		for (int b = 0; b < LINE_BYTES; b++)
			l[8*b +: 8] = addr[7:0] + 8'(b) + 8'(addr[31:29]);
		return l;
	endfunction

	// A transfer completes once its stretch count has run down to zero.
	assign mem_waitrequest = !(mem_req.read || mem_req.write) || wait_cnt != '0;

	always @(negedge clk)
		mem_readdata <= stored_line(mem_req.address); // Settles well ahead of the next edge.

	always @(posedge clk or negedge rst_n) begin : transfer
		logic [31:0] next_state;
		line         merged;
		if (!rst_n) begin
			lcg_state <= SEED;
			wait_cnt <= SEED[31:30];
		end else if (mem_req.read || mem_req.write) begin
			if (wait_cnt != '0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				if (mem_req.write) begin
					merged = stored_line(mem_req.address);
					for (int b = 0; b < LINE_BYTES; b++)
						if (mem_req.byteenable[b])
							merged[8*b +: 8] = mem_req.writedata[8*b +: 8];
					lines[mem_req.address] = merged;
				end
				next_state = lcg_next(lcg_state);
				lcg_state <= next_state;
				wait_cnt <= next_state[31:30]; // Stretch of the following transfer.
			end
		end
	end

endmodule

// File: dv/cache_tb.sv
module cache_tb
	import cache_pkg::*;
	import bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF     = 10;
	localparam int DRIVE_DELAY  = 2;
	localparam int SAMPLE_DELAY = 16; // Late in the cycle, after memory read data has settled.
	localparam int MAX_WAIT     = 200;
	localparam int MAX_RECORDS  = 32;
	localparam int REC_WORDS    = 5;  // Op, address, writedata, byteenable, expected data.

	localparam logic [7:0] OP_END   = 8'h00;
	localparam logic [7:0] OP_READ  = 8'h01;
	localparam logic [7:0] OP_WRITE = 8'h02;

	logic      clk = 1'b0;
	logic      rst_n;
	core_req_t core_req;
	logic      core_waitrequest;
	line       core_readdata;
	mem_req_t  mem_req;
	logic      mem_waitrequest;
	line       mem_readdata;

	line patterns [REC_WORDS*MAX_RECORDS];

	// Which tag each index holds, so that the hits are known in advance.
	logic [NUM_LINES-1:0] line_valid;
	addr_tag              line_tag [NUM_LINES];

	cache_top dut_i (
		.clk, .rst_n,
		.core_req, .core_waitrequest, .core_readdata,
		.mem_req, .mem_waitrequest, .mem_readdata
	);

	cache_mem_model mem_i (
		.clk, .rst_n,
		.mem_req, .mem_waitrequest, .mem_readdata
	);

	always #CLK_HALF clk = !clk;

	task automatic check_value(input string name, input line expected, input line actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "Value mismatch in %s.", name);
		end
	endtask

	// Called at a sample point; returns at the sample point before the completing edge.
	task automatic wait_ready(input string name, output int cycles);
		cycles = 0;
		while (core_waitrequest) begin
			if (cycles == MAX_WAIT) begin
				$display("%s: timeout waiting for core_waitrequest", name);
				$display("TEST FAIL");
				$fatal(1, "Core request never completed.");
			end
			cycles++;
			@(posedge clk);
			#SAMPLE_DELAY;
		end
	endtask

	task automatic run_record(input int rec);
		logic [7:0] op;
		addr_t      addr;
		string      name;
		logic       cached;
		logic       expect_hit;
		int         cycles;
		op = 8'(patterns[REC_WORDS*rec]);
		addr.flat = word'(patterns[REC_WORDS*rec + 1]);
		name = $sformatf("record %0d (%s %h)", rec,
			op == OP_READ ? "read" : "write", addr.flat);
		if (op != OP_READ && op != OP_WRITE) begin
			$display("Record %0d has an unknown operation code %h.", rec, op);
			$display("TEST FAIL");
			$fatal(1, "Bad pattern file.");
		end
		cached = addr.f.region == CACHED_REGION;
		expect_hit = cached && line_valid[addr.f.index]
			&& line_tag[addr.f.index] == addr.f.tag;
		@(posedge clk);
		#DRIVE_DELAY;
		core_req.address = addr;
		core_req.read = op == OP_READ;
		core_req.write = op == OP_WRITE;
		core_req.writedata = patterns[REC_WORDS*rec + 2];
		core_req.byteenable = line_be'(patterns[REC_WORDS*rec + 3]);
		#(SAMPLE_DELAY - DRIVE_DELAY);
		wait_ready(name, cycles);
		if (expect_hit)
			check_value({name, " latency"}, line'(1), line'(cycles)); // One wait cycle on a hit.
		if (op == OP_READ)
			check_value(name, patterns[REC_WORDS*rec + 4], core_readdata);
		if (cached) begin
			line_valid[addr.f.index] = 1'b1; // Reads and writes both allocate.
			line_tag[addr.f.index] = addr.f.tag;
		end
		@(posedge clk); // The transfer completes on this edge.
		#DRIVE_DELAY;
		core_req.read = 1'b0;
		core_req.write = 1'b0;
	endtask

	initial begin
		int rec;
		core_req = '0;
		rst_n = 1'b0;
		line_valid = '0;
		foreach (patterns[i])
			patterns[i] = '0;
		$readmemh("dv/cache_patterns.hex", patterns);
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		rec = 0;
		while (rec < MAX_RECORDS && 8'(patterns[REC_WORDS*rec]) != OP_END) begin
			run_record(rec);
			rec++;
		end
		if (rec == 0) begin
			$display("No pattern records were loaded.");
			$display("TEST FAIL");
			$fatal(1, "Empty pattern file.");
		end else begin
			$display("Replayed %0d records.", rec);
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: dv/cache_patterns.hex
// op addr     writedata                        be   expected read data
// op 1 reads, 2 writes, 0 ends the list. Write records expect nothing.
// Read miss then hit on a clean line.
1 00000120 00000000000000000000000000000000 0000 2f2e2d2c2b2a29282726252423222120
1 00000120 00000000000000000000000000000000 0000 2f2e2d2c2b2a29282726252423222120
// Sparse write hit, then read back the merged line.
2 00000120 cfcecdcccbcac9c8c7c6c5c4c3c2c1c0 8421 00000000000000000000000000000000
1 00000120 00000000000000000000000000000000 0000 cf2e2d2c2bca29282726c524232221c0
// Conflicting tag evicts the dirty line, which comes back from memory.
1 00000520 00000000000000000000000000000000 0000 2f2e2d2c2b2a29282726252423222120
1 00000120 00000000000000000000000000000000 0000 cf2e2d2c2bca29282726c524232221c0
// Write miss at an unaligned address, then eviction and re-read.
2 00000344 55555555555555555555555555555555 00f0 00000000000000000000000000000000
1 00000340 00000000000000000000000000000000 0000 4f4e4d4c4b4a49485555555543424140
1 00000740 00000000000000000000000000000000 0000 4f4e4d4c4b4a49484746454443424140
1 0000034c 00000000000000000000000000000000 0000 4f4e4d4c4b4a49485555555543424140
// Uncached regions go straight to memory.
1 a0000040 00000000000000000000000000000000 0000 54535251504f4e4d4c4b4a4948474645
2 20000760 0123456789abcdeffedcba9876543210 0ff0 00000000000000000000000000000000
1 20000768 00000000000000000000000000000000 0000 706f6e6d89abcdeffedcba9864636261
// The region zero alias keeps its own contents.
1 00000760 00000000000000000000000000000000 0000 6f6e6d6c6b6a69686766656463626160
1 00000768 00000000000000000000000000000000 0000 6f6e6d6c6b6a69686766656463626160
0 00000000 00000000000000000000000000000000 0000 00000000000000000000000000000000

// File: filelist.f
src/cache_pkg.sv
src/bus_pkg.sv
src/cache_routing.sv
src/cache_ctrl.sv
src/cache_store.sv
src/cache_top.sv
dv/cache_mem_model.sv
dv/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= TEST PASS

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
